/* logic/dram_cfg_pkg.sv */
// DRAM subsystem sizes, address layout and width types
package dram_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SoC and memory port sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SOC_DATA_W = 32;
  localparam int unsigned SOC_STRB_W = SOC_DATA_W / 8;
  localparam int unsigned SOC_ADDR_W = 16;
  localparam int unsigned SOC_ID_W   = 4;

  localparam int unsigned MEM_DATA_W = 64;
  localparam int unsigned MEM_STRB_W = MEM_DATA_W / 8;
  localparam int unsigned MEM_ADDR_W = 11;
  localparam int unsigned MEM_TAG_W  = 2;

  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);
  localparam int unsigned BANK_ROW_W = $clog2(BANK_WORDS);

  // Address layout: byte in word, then bank, then row
  localparam int unsigned HALF_BIT = $clog2(SOC_STRB_W);
  localparam int unsigned BANK_LSB = $clog2(MEM_STRB_W);
  localparam int unsigned ROW_LSB  = BANK_LSB + BANK_SEL_W;

  typedef logic [SOC_DATA_W-1:0] soc_data_t;
  typedef logic [SOC_STRB_W-1:0] soc_strb_t;
  typedef logic [SOC_ADDR_W-1:0] soc_addr_t;
  typedef logic [SOC_ID_W-1:0]   soc_id_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;
  typedef logic [MEM_STRB_W-1:0] mem_strb_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [MEM_TAG_W-1:0]  mem_tag_t;
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [BANK_ROW_W-1:0] bank_row_t;

endpackage

/* logic/dram_bus_pkg.sv */
// DRAM subsystem request and response structs and adapter FSM states
package dram_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SoC side
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   write;
    dram_cfg_pkg::soc_addr_t addr;
    dram_cfg_pkg::soc_id_t   id;
    dram_cfg_pkg::soc_data_t data;
    dram_cfg_pkg::soc_strb_t strb;
  } soc_req_t;

  typedef struct packed {
    dram_cfg_pkg::soc_id_t   id;
    dram_cfg_pkg::soc_data_t data;
    logic                    error;
  } soc_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                    write;
    dram_cfg_pkg::mem_addr_t addr;
    dram_cfg_pkg::mem_tag_t  tag;
    dram_cfg_pkg::mem_data_t data;
    dram_cfg_pkg::mem_strb_t strb;
  } mem_req_t;

  typedef struct packed {
    dram_cfg_pkg::mem_tag_t  tag;
    dram_cfg_pkg::mem_data_t data;
  } mem_rsp_t;

  // Router to bank, address already split into row
  typedef struct packed {
    logic                    write;
    dram_cfg_pkg::bank_row_t row;
    dram_cfg_pkg::mem_tag_t  tag;
    dram_cfg_pkg::mem_data_t data;
    dram_cfg_pkg::mem_strb_t strb;
  } bank_req_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    RESP
  } adapter_state_e;

endpackage

/* logic/dram_port_adapter.sv */
// SoC port adapter: data width and ID resizing with address truncation
module dram_port_adapter (
  input  logic                   soc_clk_i,
  input  logic                   rst_n_i,
  // SoC request and response
  input  logic                   soc_req_valid_i,
  output logic                   soc_req_ready_o,
  input  dram_bus_pkg::soc_req_t soc_req_i,
  output logic                   soc_rsp_valid_o,
  input  logic                   soc_rsp_ready_i,
  output dram_bus_pkg::soc_rsp_t soc_rsp_o,
  // Memory side strobes
  output logic                   mem_req_valid_o,
  output dram_bus_pkg::mem_req_t mem_req_o,
  input  logic                   mem_rsp_valid_i,
  input  dram_bus_pkg::mem_rsp_t mem_rsp_i
);

  dram_bus_pkg::adapter_state_e state_q, state_d;
  dram_cfg_pkg::mem_tag_t       tag_q, tag_next;
  dram_bus_pkg::mem_req_t       mem_req_q;
  dram_cfg_pkg::soc_id_t        id_q;
  dram_cfg_pkg::soc_data_t      rdata_q;
  logic                         half_q;
  logic                         err_q;
  logic                         req_fire;
  logic                         rsp_match;
  logic                         addr_alias;

  assign soc_req_ready_o = (state_q == dram_bus_pkg::IDLE);
  assign req_fire        = soc_req_valid_i && soc_req_ready_o;
  assign tag_next        = tag_q + 1'b1;

  // Any SoC address bit beyond the store aliases back into it
  assign addr_alias = |soc_req_i.addr[dram_cfg_pkg::SOC_ADDR_W-1:dram_cfg_pkg::MEM_ADDR_W];

  // Stale tags are dropped
  assign rsp_match = (state_q == dram_bus_pkg::WAIT) && mem_rsp_valid_i &&
                     (mem_rsp_i.tag == mem_req_q.tag);

  always_comb begin
    state_d = state_q;
    case (state_q)
      dram_bus_pkg::IDLE:  if (req_fire) state_d = dram_bus_pkg::ISSUE;
      dram_bus_pkg::ISSUE: state_d = dram_bus_pkg::WAIT;
      dram_bus_pkg::WAIT:  if (rsp_match) state_d = dram_bus_pkg::RESP;
      dram_bus_pkg::RESP:  if (soc_rsp_ready_i) state_d = dram_bus_pkg::IDLE;
      default:             state_d = dram_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      state_q <= dram_bus_pkg::IDLE;
      tag_q   <= '0;
    end else begin
      state_q <= state_d;
      if (req_fire) begin
        tag_q <= tag_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request widening
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk_i) begin
    if (req_fire) begin
      half_q          <= soc_req_i.addr[dram_cfg_pkg::HALF_BIT];
      id_q            <= soc_req_i.id;
      err_q           <= addr_alias;
      mem_req_q.write <= soc_req_i.write;
      mem_req_q.addr  <= soc_req_i.addr[dram_cfg_pkg::MEM_ADDR_W-1:0];
      mem_req_q.tag   <= tag_next;
      // Place the beat in the addressed half of the word
      if (soc_req_i.addr[dram_cfg_pkg::HALF_BIT]) begin
        mem_req_q.data <= {soc_req_i.data, {dram_cfg_pkg::SOC_DATA_W{1'b0}}};
        mem_req_q.strb <= {soc_req_i.strb, {dram_cfg_pkg::SOC_STRB_W{1'b0}}};
      end else begin
        mem_req_q.data <= {{dram_cfg_pkg::SOC_DATA_W{1'b0}}, soc_req_i.data};
        mem_req_q.strb <= {{dram_cfg_pkg::SOC_STRB_W{1'b0}}, soc_req_i.strb};
      end
    end
  end

  assign mem_req_valid_o = (state_q == dram_bus_pkg::ISSUE);
  assign mem_req_o       = mem_req_q;

  // Response narrowing, writes return zero
  always_ff @(posedge soc_clk_i) begin
    if (rsp_match) begin
      if (mem_req_q.write) begin
        rdata_q <= '0;
      end else if (half_q) begin
        rdata_q <= mem_rsp_i.data[dram_cfg_pkg::MEM_DATA_W-1:dram_cfg_pkg::SOC_DATA_W];
      end else begin
        rdata_q <= mem_rsp_i.data[dram_cfg_pkg::SOC_DATA_W-1:0];
      end
    end
  end

  assign soc_rsp_valid_o = (state_q == dram_bus_pkg::RESP);
  assign soc_rsp_o.id    = id_q;
  assign soc_rsp_o.data  = rdata_q;
  assign soc_rsp_o.error = err_q;

endmodule

/* logic/dram_bank_router.sv */
// Bank router: registers a memory request and strobes the addressed bank
module dram_bank_router (
  input  logic                                  soc_clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  mem_req_valid_i,
  input  dram_bus_pkg::mem_req_t                mem_req_i,
  output logic [dram_cfg_pkg::NUM_BANKS-1:0]    bank_req_valid_o,
  output dram_bus_pkg::bank_req_t               bank_req_o
);

  dram_cfg_pkg::bank_sel_t                bank_sel;
  dram_cfg_pkg::bank_row_t                row;
  logic [dram_cfg_pkg::NUM_BANKS-1:0]     valid_q;
  dram_bus_pkg::bank_req_t                req_q;

  // Words interleave across banks
  assign bank_sel = mem_req_i.addr[dram_cfg_pkg::BANK_LSB +: dram_cfg_pkg::BANK_SEL_W];
  assign row      = mem_req_i.addr[dram_cfg_pkg::ROW_LSB +: dram_cfg_pkg::BANK_ROW_W];

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= '0;
      if (mem_req_valid_i) begin
        valid_q[bank_sel] <= 1'b1;
      end
    end
  end

  // Payload shared by all banks
  always_ff @(posedge soc_clk_i) begin
    if (mem_req_valid_i) begin
      req_q.write <= mem_req_i.write;
      req_q.row   <= row;
      req_q.tag   <= mem_req_i.tag;
      req_q.data  <= mem_req_i.data;
      req_q.strb  <= mem_req_i.strb;
    end
  end

  assign bank_req_valid_o = valid_q;
  assign bank_req_o       = req_q;

endmodule

/* logic/dram_bank.sv */
// Memory bank: byte-strobed word store with a registered response
module dram_bank (
  input  logic                    soc_clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  dram_bus_pkg::bank_req_t req_i,
  output logic                    rsp_valid_o,
  output dram_bus_pkg::mem_rsp_t  rsp_o
);

  dram_cfg_pkg::mem_data_t mem_q [dram_cfg_pkg::BANK_WORDS];
  dram_cfg_pkg::mem_data_t rdata_q;
  dram_cfg_pkg::mem_tag_t  tag_q;
  logic                    rsp_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Only the enabled bytes of the row change
  always_ff @(posedge soc_clk_i) begin
    if (req_valid_i && req_i.write) begin
      for (int b = 0; b < dram_cfg_pkg::MEM_STRB_W; b++) begin
        if (req_i.strb[b]) begin
          mem_q[req_i.row][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
  end

  // Read port, returns the word as it was before a write in the same cycle
  always_ff @(posedge soc_clk_i) begin
    if (req_valid_i) begin
      rdata_q <= mem_q[req_i.row];
      tag_q   <= req_i.tag;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.tag   = tag_q;
  assign rsp_o.data  = rdata_q;

endmodule

/* logic/dram_rsp_collector.sv */
// Response collector: merges one-hot bank responses into a single stream
module dram_rsp_collector (
  input  logic                               soc_clk_i,
  input  logic                               rst_n_i,
  input  logic [dram_cfg_pkg::NUM_BANKS-1:0] bank_rsp_valid_i,
  input  dram_bus_pkg::mem_rsp_t             bank_rsp_i [dram_cfg_pkg::NUM_BANKS],
  output logic                               mem_rsp_valid_o,
  output dram_bus_pkg::mem_rsp_t             mem_rsp_o
);

  dram_bus_pkg::mem_rsp_t rsp_sel;
  dram_bus_pkg::mem_rsp_t rsp_q;
  logic                   any_valid;
  logic                   valid_q;

  assign any_valid = |bank_rsp_valid_i;

  // At most one bank answers per cycle
  always_comb begin
    rsp_sel = '0;
    for (int b = 0; b < dram_cfg_pkg::NUM_BANKS; b++) begin
      if (bank_rsp_valid_i[b]) begin
        rsp_sel = bank_rsp_i[b];
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= any_valid;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (any_valid) begin
      rsp_q <= rsp_sel;
    end
  end

  assign mem_rsp_valid_o = valid_q;
  assign mem_rsp_o       = rsp_q;

endmodule

/* logic/dram_subsystem.sv */
// DRAM subsystem top: port adapter, bank router, bank array and collector
module dram_subsystem (
  input  logic                   soc_clk_i,
  input  logic                   rst_n_i,
  input  logic                   soc_req_valid_i,
  output logic                   soc_req_ready_o,
  input  dram_bus_pkg::soc_req_t soc_req_i,
  output logic                   soc_rsp_valid_o,
  input  logic                   soc_rsp_ready_i,
  output dram_bus_pkg::soc_rsp_t soc_rsp_o
);

  logic                               mem_req_valid;
  dram_bus_pkg::mem_req_t             mem_req;
  logic [dram_cfg_pkg::NUM_BANKS-1:0] bank_req_valid;
  dram_bus_pkg::bank_req_t            bank_req;
  logic [dram_cfg_pkg::NUM_BANKS-1:0] bank_rsp_valid;
  dram_bus_pkg::mem_rsp_t             bank_rsp [dram_cfg_pkg::NUM_BANKS];
  logic                               mem_rsp_valid;
  dram_bus_pkg::mem_rsp_t             mem_rsp;

  dram_port_adapter u_port_adapter (
    .soc_clk_i       (soc_clk_i),
    .rst_n_i         (rst_n_i),
    .soc_req_valid_i (soc_req_valid_i),
    .soc_req_ready_o (soc_req_ready_o),
    .soc_req_i       (soc_req_i),
    .soc_rsp_valid_o (soc_rsp_valid_o),
    .soc_rsp_ready_i (soc_rsp_ready_i),
    .soc_rsp_o       (soc_rsp_o),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_i       (mem_rsp)
  );

  dram_bank_router u_bank_router (
    .soc_clk_i        (soc_clk_i),
    .rst_n_i          (rst_n_i),
    .mem_req_valid_i  (mem_req_valid),
    .mem_req_i        (mem_req),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_o       (bank_req)
  );

  // One store per bank select value
  for (genvar b = 0; b < dram_cfg_pkg::NUM_BANKS; b++) begin : gen_bank
    dram_bank u_bank (
      .soc_clk_i   (soc_clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (bank_req_valid[b]),
      .req_i       (bank_req),
      .rsp_valid_o (bank_rsp_valid[b]),
      .rsp_o       (bank_rsp[b])
    );
  end

  dram_rsp_collector u_rsp_collector (
    .soc_clk_i        (soc_clk_i),
    .rst_n_i          (rst_n_i),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_i       (bank_rsp),
    .mem_rsp_valid_o  (mem_rsp_valid),
    .mem_rsp_o        (mem_rsp)
  );

endmodule

/* verif/tb_clk_gen.sv */
// Clock and reset source for the testbench, 100 ns period
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned HALF_PERIOD  = 50;
  localparam int unsigned RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset released just after the third rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/tb_dram_checker.sv */
// Response checker: pairs each SoC response with its accepted request
module tb_dram_checker (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    soc_req_valid_i,
  input  logic                    soc_req_ready_i,
  input  dram_bus_pkg::soc_req_t  soc_req_i,
  input  logic                    soc_rsp_valid_i,
  input  logic                    soc_rsp_ready_i,
  input  dram_bus_pkg::soc_rsp_t  soc_rsp_i,
  input  dram_cfg_pkg::soc_data_t exp_data_i,
  input  logic                    exp_err_i,
  input  int unsigned             test_idx_i,
  output int unsigned             done_cnt_o,
  output int unsigned             fail_cnt_o,
  output int unsigned             err_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RSP_LATENCY = 4;

  typedef struct packed {
    int unsigned             test;
    dram_cfg_pkg::soc_id_t   id;
    dram_cfg_pkg::soc_data_t data;
    logic                    error;
    int unsigned             accept_cycle;
  } pending_t;

  pending_t               pending_q [$];
  pending_t               head;
  dram_bus_pkg::soc_rsp_t held_rsp;
  int unsigned            cycle_cnt;
  int unsigned            test_errs;
  int unsigned            latency;
  logic                   rsp_valid_prev;

  task automatic print_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("MISMATCH test %0d %s: got 0x%0h expected 0x%0h", head.test, name, got, exp);
    test_errs++;
    err_cnt_o++;
  endtask

  task automatic note_failure(input string what);
    $display("test %0d: %s", head.test, what);
    test_errs++;
    err_cnt_o++;
  endtask

  // Compare the transferred response and retire its request
  task automatic close_test();
    if (soc_rsp_i.id !== head.id)
      print_mismatch("soc_rsp_o.id", soc_rsp_i.id, head.id);
    if (soc_rsp_i.data !== head.data)
      print_mismatch("soc_rsp_o.data", soc_rsp_i.data, head.data);
    if (soc_rsp_i.error !== head.error)
      print_mismatch("soc_rsp_o.error", soc_rsp_i.error, head.error);
    if (test_errs == 0) begin
      $display("test %0d passed: id 0x%h data 0x%h error %0d", head.test,
               soc_rsp_i.id, soc_rsp_i.data, soc_rsp_i.error);
    end else begin
      $display("test %0d failed with %0d errors", head.test, test_errs);
      fail_cnt_o++;
    end
    done_cnt_o++;
    test_errs = 0;
    void'(pending_q.pop_front());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sampled on the rising edge, as the DUT sees it
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q.delete();
      cycle_cnt      = 0;
      test_errs      = 0;
      rsp_valid_prev = 1'b0;
    end else begin
      cycle_cnt++;
      if (soc_req_valid_i && soc_req_ready_i)
        pending_q.push_back('{test_idx_i, soc_req_i.id, exp_data_i, exp_err_i, cycle_cnt});
      if (soc_rsp_valid_i && pending_q.size() == 0) begin
        if (!rsp_valid_prev) begin
          $display("response with no pending request at cycle %0d", cycle_cnt);
          err_cnt_o++;
        end
      end else if (soc_rsp_valid_i) begin
        head = pending_q[0];
        if (!rsp_valid_prev) begin
          // Seen one edge after the adapter registered it
          latency = cycle_cnt - 1 - head.accept_cycle;
          if (latency != RSP_LATENCY)
            note_failure($sformatf("response came %0d cycles after acceptance, not %0d",
                                   latency, RSP_LATENCY));
          held_rsp = soc_rsp_i;
        end else if (soc_rsp_i !== held_rsp) begin
          print_mismatch("soc_rsp_o held", soc_rsp_i, held_rsp);
        end
        if (soc_req_ready_i)
          note_failure("soc_req_ready_o went high while a response was held");
        if (soc_rsp_ready_i)
          close_test();
      end
      rsp_valid_prev = soc_rsp_valid_i;
    end
  end

endmodule

/* verif/tb_dram_subsystem.sv */
// Testbench top that drives pattern requests into the DRAM subsystem
module tb_dram_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MAX_PATTERNS    = 64;
  localparam int unsigned CYCLES_PER_TEST = 12;
  localparam int unsigned TIMEOUT_SLACK   = 20;

  // One pattern line with every field padded to whole hex digits
  typedef struct packed {
    logic [3:0]              write;
    dram_cfg_pkg::soc_addr_t addr;
    dram_cfg_pkg::soc_id_t   id;
    dram_cfg_pkg::soc_data_t wdata;
    dram_cfg_pkg::soc_strb_t strb;
    dram_cfg_pkg::soc_data_t exp_data;
    logic [3:0]              exp_err;
  } pattern_t;

  pattern_t                patterns [MAX_PATTERNS];
  int unsigned             num_patterns;
  int unsigned             timeout_limit;
  int unsigned             cycle_cnt;
  integer                  seed;
  logic                    clk;
  logic                    rst_n;
  logic                    soc_req_valid;
  logic                    soc_req_ready;
  dram_bus_pkg::soc_req_t  soc_req;
  logic                    soc_rsp_valid;
  logic                    soc_rsp_ready;
  dram_bus_pkg::soc_rsp_t  soc_rsp;
  dram_cfg_pkg::soc_data_t exp_data;
  logic                    exp_err;
  int unsigned             test_idx;
  int unsigned             done_cnt;
  int unsigned             fail_cnt;
  int unsigned             err_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dram_subsystem u_dram_subsystem (
    .soc_clk_i       (clk),
    .rst_n_i         (rst_n),
    .soc_req_valid_i (soc_req_valid),
    .soc_req_ready_o (soc_req_ready),
    .soc_req_i       (soc_req),
    .soc_rsp_valid_o (soc_rsp_valid),
    .soc_rsp_ready_i (soc_rsp_ready),
    .soc_rsp_o       (soc_rsp)
  );

  tb_dram_checker u_checker (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .soc_req_valid_i (soc_req_valid),
    .soc_req_ready_i (soc_req_ready),
    .soc_req_i       (soc_req),
    .soc_rsp_valid_i (soc_rsp_valid),
    .soc_rsp_ready_i (soc_rsp_ready),
    .soc_rsp_i       (soc_rsp),
    .exp_data_i      (exp_data),
    .exp_err_i       (exp_err),
    .test_idx_i      (test_idx),
    .done_cnt_o      (done_cnt),
    .fail_cnt_o      (fail_cnt),
    .err_cnt_o       (err_cnt)
  );

  // Issue one pattern and complete its response after 0 to 3 held cycles
  task automatic run_pattern(input int unsigned idx);
    int unsigned hold_cycles;
    logic        seen;
    hold_cycles   = $unsigned($random(seed)) % 4;
    soc_req.write = patterns[idx].write[0];
    soc_req.addr  = patterns[idx].addr;
    soc_req.id    = patterns[idx].id;
    soc_req.data  = patterns[idx].wdata;
    soc_req.strb  = patterns[idx].strb;
    exp_data      = patterns[idx].exp_data;
    exp_err       = patterns[idx].exp_err[0];
    test_idx      = idx;
    soc_req_valid = 1'b1;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk);
      seen = soc_req_ready;
    end
    #1;
    soc_req_valid = 1'b0;
    // Without back-pressure the response transfers in its first cycle
    soc_rsp_ready = (hold_cycles == 0);
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk);
      seen = soc_rsp_valid;
    end
    // First valid cycle already counts as one held cycle
    if (hold_cycles != 0) begin
      repeat (hold_cycles - 1) @(posedge clk);
      #1;
      soc_rsp_ready = 1'b1;
      seen = 1'b0;
      while (!seen) begin
        @(posedge clk);
        seen = soc_rsp_valid;
      end
    end
    #1;
    soc_rsp_ready = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    seed          = 32'hf65e_e72f;
    soc_req_valid = 1'b0;
    soc_req       = '0;
    soc_rsp_ready = 1'b0;
    exp_data      = '0;
    exp_err       = 1'b0;
    test_idx      = 0;
    num_patterns  = 0;
    $readmemh("verif/dram_patterns.hex", patterns);
    while (num_patterns < MAX_PATTERNS && !$isunknown(patterns[num_patterns]))
      num_patterns++;
    timeout_limit = num_patterns * CYCLES_PER_TEST + TIMEOUT_SLACK;
    wait (rst_n === 1'b1);
    for (int unsigned i = 0; i < num_patterns; i++)
      run_pattern(i);
    while (done_cnt < num_patterns)
      @(posedge clk);
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             num_patterns, done_cnt - fail_cnt, fail_cnt, err_cnt);
    if (num_patterns != 0 && fail_cnt == 0 && err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* list.f */
logic/dram_cfg_pkg.sv
logic/dram_bus_pkg.sv
logic/dram_port_adapter.sv
logic/dram_bank_router.sv
logic/dram_bank.sv
logic/dram_rsp_collector.sv
logic/dram_subsystem.sv
verif/tb_clk_gen.sv
verif/tb_dram_checker.sv
verif/tb_dram_subsystem.sv

/* Bender.yml */
package:
  name: dram_subsystem

sources:
  - logic/dram_cfg_pkg.sv
  - logic/dram_bus_pkg.sv
  - logic/dram_port_adapter.sv
  - logic/dram_bank_router.sv
  - logic/dram_bank.sv
  - logic/dram_rsp_collector.sv
  - logic/dram_subsystem.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_dram_checker.sv
      - verif/tb_dram_subsystem.sv

/* verif/dram_patterns.hex */
// Columns: write _ address _ id _ write data _ strobes _ expected read data _ expected error
// Each line is one 96-bit word, fields joined by underscores
1_0040_3_deadbeef_f_00000000_0
0_0040_5_00000000_0_deadbeef_0
1_0044_a_cafef00d_f_00000000_0
0_0044_c_00000000_0_cafef00d_0
0_0040_1_00000000_0_deadbeef_0
1_00a8_2_11223344_f_00000000_0
1_00ac_3_55667788_f_00000000_0
1_00a8_4_aabbccdd_5_00000000_0
1_00ac_5_99eeff00_8_00000000_0
0_00a8_6_00000000_0_11bb33dd_0
0_00ac_7_00000000_0_99667788_0
1_00ac_8_0000ab00_2_00000000_0
0_00ac_9_00000000_0_9966ab88_0
0_00a8_a_00000000_0_11bb33dd_0
1_00e0_0_b0b0b0b0_f_00000000_0
1_00e8_1_b1b1b1b1_f_00000000_0
1_00f0_2_b2b2b2b2_f_00000000_0
1_00f8_3_b3b3b3b3_f_00000000_0
0_00f0_4_00000000_0_b2b2b2b2_0
0_00e0_5_00000000_0_b0b0b0b0_0
0_00f8_6_00000000_0_b3b3b3b3_0
0_00e8_7_00000000_0_b1b1b1b1_0
0_0840_b_00000000_0_deadbeef_1
0_f844_d_00000000_0_cafef00d_1
1_88a8_c_12345678_f_00000000_1
0_00a8_d_00000000_0_12345678_0
0_48a8_e_00000000_0_12345678_1
1_07f8_f_0f1e2d3c_f_00000000_0
0_07f8_0_00000000_0_0f1e2d3c_0
1_07fc_6_a5a5a5a5_f_00000000_0
0_07fc_9_00000000_0_a5a5a5a5_0
0_07f8_3_00000000_0_0f1e2d3c_0
